// ==== logic/dram_defs.svh ====
`ifndef DRAM_DEFS_SVH
`define DRAM_DEFS_SVH

// counter widths
`define DRAM_CNT_W 6
`define DRAM_REF_W 12

// address fields of one request
`define DRAM_BANK_W 2
`define DRAM_ROW_W 14
`define DRAM_COL_W 10

// fixed burst, BL8 on a DDR bus
`define DRAM_TBURST 4

// timing register values after reset, in controller cycles
`define DRAM_RST_TRCD 5
`define DRAM_RST_TRP 5
`define DRAM_RST_TRFC 20
`define DRAM_RST_TRL 6
`define DRAM_RST_TWL 4
`define DRAM_RST_TREFI 1560

// word addresses on the configuration port
`define DRAM_ADR_TRCD 3'd0
`define DRAM_ADR_TRP 3'd1
`define DRAM_ADR_TRFC 3'd2
`define DRAM_ADR_TRL 3'd3
`define DRAM_ADR_TWL 3'd4
`define DRAM_ADR_TREFI 3'd5

`endif

// ==== logic/dram_pkg.sv ====
`include "dram_defs.svh"

package dram_pkg;

    // cycle counts
    typedef logic [`DRAM_CNT_W-1:0] cnt_t;
    typedef logic [`DRAM_REF_W-1:0] ref_t;

    // address fields
    typedef logic [`DRAM_BANK_W-1:0] bank_t;
    typedef logic [`DRAM_ROW_W-1:0] row_t;
    typedef logic [`DRAM_COL_W-1:0] col_t;

    // command states are followed by their wait states
    typedef enum logic [3:0] {
        IDLE,
        ACTIVATE,
        ACTIVATING,
        READ,
        READING,
        WRITE,
        WRITING,
        PRECHARGE,
        PRECHARGING,
        REFRESH,
        REFRESHING
    } cmd_state_t;

    // command bus codes
    typedef enum logic [2:0] {
        NOP,
        ACT,
        RD,
        WR,
        PRE,
        REF
    } dram_cmd_e;

    // one host request
    typedef struct packed {
        logic  write;
        bank_t bank;
        row_t  row;
        col_t  col;
    } mem_req_t;

    // one command bus word
    typedef struct packed {
        dram_cmd_e code;
        bank_t     bank;
        row_t      row;
        col_t      col;
    } dram_cmd_t;

    // programmable timing, read live by the timing controller
    typedef struct packed {
        cnt_t trcd;
        cnt_t trp;
        cnt_t trfc;
        cnt_t trl;
        cnt_t twl;
        ref_t trefi;
    } timing_cfg_t;

endpackage

// ==== logic/flex_counter.sv ====
`include "dram_defs.svh"

module flex_counter (
    input  logic            clk,
    input  logic            nRST,
    input  logic            load,
    input  dram_pkg::cnt_t  load_val,
    output dram_pkg::cnt_t  count,
    output logic            done
);

    dram_pkg::cnt_t cnt_q;

    // the load cycle already shows the new value
    assign count = load ? load_val : cnt_q;

    // last cycle of the interval, so N-1 cycles after a load of N
    assign done = !load && (cnt_q == dram_pkg::cnt_t'(1));

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            cnt_q <= '0;
        end else if (count > dram_pkg::cnt_t'(1)) begin
            cnt_q <= count - 1'b1;
        end else begin
            // parked at one until the next load
            cnt_q <= count;
        end
    end

    // an interval of zero cycles would never report done
    assert property (@(posedge clk) disable iff (!nRST) load |-> (load_val != '0))
        else $error("flex_counter: zero interval loaded");

endmodule

// ==== logic/timing_regs.sv ====
`include "dram_defs.svh"

module timing_regs (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  logic [15:0]          wb_dat_w,
    output logic [15:0]          wb_dat_r,
    output logic                 wb_ack,
    output dram_pkg::timing_cfg_t cfg
);

    dram_pkg::timing_cfg_t cfg_q;
    logic                  wb_req;
    logic [15:0]           rd_data;

    // new cycle only, so a held strobe gets one ack per access
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    assign cfg = cfg_q;

    // read mux, fields zero-extended
    always_comb begin
        case (wb_adr)
            `DRAM_ADR_TRCD:  rd_data = 16'(cfg_q.trcd);
            `DRAM_ADR_TRP:   rd_data = 16'(cfg_q.trp);
            `DRAM_ADR_TRFC:  rd_data = 16'(cfg_q.trfc);
            `DRAM_ADR_TRL:   rd_data = 16'(cfg_q.trl);
            `DRAM_ADR_TWL:   rd_data = 16'(cfg_q.twl);
            `DRAM_ADR_TREFI: rd_data = 16'(cfg_q.trefi);
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            wb_ack      <= 1'b0;
            cfg_q.trcd  <= dram_pkg::cnt_t'(`DRAM_RST_TRCD);
            cfg_q.trp   <= dram_pkg::cnt_t'(`DRAM_RST_TRP);
            cfg_q.trfc  <= dram_pkg::cnt_t'(`DRAM_RST_TRFC);
            cfg_q.trl   <= dram_pkg::cnt_t'(`DRAM_RST_TRL);
            cfg_q.twl   <= dram_pkg::cnt_t'(`DRAM_RST_TWL);
            cfg_q.trefi <= dram_pkg::ref_t'(`DRAM_RST_TREFI);
        end else begin
            wb_ack <= wb_req;
            // new value is visible in the ack cycle
            if (wb_req && wb_we) begin
                case (wb_adr)
                    `DRAM_ADR_TRCD:  cfg_q.trcd  <= dram_pkg::cnt_t'(wb_dat_w);
                    `DRAM_ADR_TRP:   cfg_q.trp   <= dram_pkg::cnt_t'(wb_dat_w);
                    `DRAM_ADR_TRFC:  cfg_q.trfc  <= dram_pkg::cnt_t'(wb_dat_w);
                    `DRAM_ADR_TRL:   cfg_q.trl   <= dram_pkg::cnt_t'(wb_dat_w);
                    `DRAM_ADR_TWL:   cfg_q.twl   <= dram_pkg::cnt_t'(wb_dat_w);
                    `DRAM_ADR_TREFI: cfg_q.trefi <= dram_pkg::ref_t'(wb_dat_w);
                    // unmapped, write dropped
                    default: ;
                endcase
            end
        end
    end

    // read data travels with the ack
    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_r <= rd_data;
        end
    end

    // classic master keeps cyc and stb up until the ack
    assert property (@(posedge clk) disable iff (!nRST)
        (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && wb_stb))
        else $error("timing_regs: strobe dropped before ack");

endmodule

// ==== logic/timing_control.sv ====
`include "dram_defs.svh"

module timing_control (
    input  logic                  clk,
    input  logic                  nRST,
    input  dram_pkg::timing_cfg_t cfg,
    input  dram_pkg::cmd_state_t  cmd_state,
    output logic                  act_done,
    output logic                  rd_done,
    output logic                  wr_done,
    output logic                  pre_done,
    output logic                  ref_done,
    output logic                  rf_req,
    output logic                  wdata_en
);

    logic           t_load;
    dram_pkg::cnt_t t_load_val;
    dram_pkg::cnt_t t_count;
    logic           t_done;

    dram_pkg::ref_t ref_cnt;
    dram_pkg::ref_t ref_debt;
    dram_pkg::ref_t ref_limit;

    // interval per command, loaded in the command cycle itself
    always_comb begin
        t_load     = 1'b1;
        t_load_val = cfg.trcd;
        case (cmd_state)
            dram_pkg::ACTIVATE:  t_load_val = cfg.trcd;
            // read latency plus the burst before the bank may close
            dram_pkg::READ:      t_load_val = dram_pkg::cnt_t'(cfg.trl + `DRAM_TBURST);
            dram_pkg::WRITE:     t_load_val = dram_pkg::cnt_t'(cfg.twl + `DRAM_TBURST);
            dram_pkg::PRECHARGE: t_load_val = cfg.trp;
            dram_pkg::REFRESH:   t_load_val = cfg.trfc;
            default:             t_load = 1'b0;
        endcase
    end

    flex_counter i_time_counter (
        .clk      (clk),
        .nRST     (nRST),
        .load     (t_load),
        .load_val (t_load_val),
        .count    (t_count),
        .done     (t_done)
    );

    // done flags only count in their own wait state
    assign act_done = (cmd_state == dram_pkg::ACTIVATING) && t_done;
    assign rd_done  = (cmd_state == dram_pkg::READING) && t_done;
    assign wr_done  = (cmd_state == dram_pkg::WRITING) && t_done;
    assign pre_done = (cmd_state == dram_pkg::PRECHARGING) && t_done;
    assign ref_done = (cmd_state == dram_pkg::REFRESHING) && t_done;

    // burst occupies the last tBURST cycles before PRE, tWL=0 starts on WR
    assign wdata_en = (cmd_state inside {dram_pkg::WRITE, dram_pkg::WRITING})
                   && (t_count <= dram_pkg::cnt_t'(`DRAM_TBURST));

    // late refresh shortens the next interval by the overshoot
    assign ref_limit = (ref_debt >= cfg.trefi) ? '0 : cfg.trefi - ref_debt;
    assign rf_req    = (ref_cnt >= ref_limit);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            ref_cnt  <= '0;
            ref_debt <= '0;
        end else if (cmd_state == dram_pkg::REFRESH) begin
            ref_cnt  <= '0;
            ref_debt <= (ref_cnt > cfg.trefi) ? ref_cnt - cfg.trefi : '0;
        end else if (ref_cnt != '1) begin
            // saturate rather than wrap back under the limit
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // the FSM may only start a refresh that was requested
    assert property (@(posedge clk) disable iff (!nRST)
        (cmd_state == dram_pkg::REFRESH) |-> $past(rf_req))
        else $error("timing_control: REFRESH without a pending request");

endmodule

// ==== logic/command_fsm.sv ====
module command_fsm (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 req_valid,
    input  dram_pkg::mem_req_t   req,
    output logic                 req_ready,
    input  logic                 act_done,
    input  logic                 rd_done,
    input  logic                 wr_done,
    input  logic                 pre_done,
    input  logic                 ref_done,
    input  logic                 rf_req,
    output dram_pkg::cmd_state_t cmd_state,
    output dram_pkg::dram_cmd_t  cmd,
    output logic                 rd_complete
);

    dram_pkg::cmd_state_t state, state_next;
    dram_pkg::mem_req_t   req_q;
    logic                 init_done;
    logic                 accept;
    logic                 wait_state;
    logic                 wait_done;

    // first cycle out of reset refuses requests
    assign req_ready = init_done && (state == dram_pkg::IDLE) && !rf_req;
    assign accept    = req_valid && req_ready;

    always_comb begin
        state_next = state;
        case (state)
            // refresh wins over a waiting request
            dram_pkg::IDLE: begin
                if (rf_req) begin
                    state_next = dram_pkg::REFRESH;
                end else if (accept) begin
                    state_next = dram_pkg::ACTIVATE;
                end
            end
            dram_pkg::ACTIVATE:    state_next = dram_pkg::ACTIVATING;
            dram_pkg::ACTIVATING: begin
                if (act_done) begin
                    state_next = req_q.write ? dram_pkg::WRITE : dram_pkg::READ;
                end
            end
            dram_pkg::READ:        state_next = dram_pkg::READING;
            dram_pkg::READING:     if (rd_done) state_next = dram_pkg::PRECHARGE;
            dram_pkg::WRITE:       state_next = dram_pkg::WRITING;
            dram_pkg::WRITING:     if (wr_done) state_next = dram_pkg::PRECHARGE;
            // close page, every access ends here
            dram_pkg::PRECHARGE:   state_next = dram_pkg::PRECHARGING;
            dram_pkg::PRECHARGING: if (pre_done) state_next = dram_pkg::IDLE;
            dram_pkg::REFRESH:     state_next = dram_pkg::REFRESHING;
            dram_pkg::REFRESHING:  if (ref_done) state_next = dram_pkg::IDLE;
            default:               state_next = dram_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state     <= dram_pkg::IDLE;
            init_done <= 1'b0;
        end else begin
            state     <= state_next;
            init_done <= 1'b1;
        end
    end

    // request held for the whole sequence
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    assign cmd_state = state;

    // one command per command state, latched address on every request command
    always_comb begin
        cmd      = '0;
        cmd.code = dram_pkg::NOP;
        if (state inside {dram_pkg::ACTIVATE, dram_pkg::READ, dram_pkg::WRITE,
                          dram_pkg::PRECHARGE}) begin
            cmd.bank = req_q.bank;
            cmd.row  = req_q.row;
            cmd.col  = req_q.col;
        end
        case (state)
            dram_pkg::ACTIVATE:  cmd.code = dram_pkg::ACT;
            dram_pkg::READ:      cmd.code = dram_pkg::RD;
            dram_pkg::WRITE:     cmd.code = dram_pkg::WR;
            dram_pkg::PRECHARGE: cmd.code = dram_pkg::PRE;
            dram_pkg::REFRESH:   cmd.code = dram_pkg::REF;
            default:             cmd.code = dram_pkg::NOP;
        endcase
    end

    // last read cycle, just before PRE
    assign rd_complete = (state == dram_pkg::READING) && rd_done;

    // wait states, and any done flag from the timing controller
    assign wait_state = state inside {dram_pkg::ACTIVATING, dram_pkg::READING,
                                      dram_pkg::WRITING, dram_pkg::PRECHARGING,
                                      dram_pkg::REFRESHING};
    assign wait_done  = act_done || rd_done || wr_done || pre_done || ref_done;

    // a done flag only shows up while a wait state is running
    assert property (@(posedge clk) disable iff (!nRST)
        wait_done |-> wait_state)
        else $error("command_fsm: done flag outside a wait state");

endmodule

// ==== logic/dram_ctrl_top.sv ====
module dram_ctrl_top (
    input  logic                clk,
    input  logic                nRST,
    // configuration port
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [2:0]          wb_adr,
    input  logic [15:0]         wb_dat_w,
    output logic [15:0]         wb_dat_r,
    output logic                wb_ack,
    // request port
    input  logic                req_valid,
    input  dram_pkg::mem_req_t  req,
    output logic                req_ready,
    // command bus and data strobes
    output dram_pkg::dram_cmd_t cmd,
    output logic                rd_complete,
    output logic                wdata_en
);

    dram_pkg::timing_cfg_t cfg;
    dram_pkg::cmd_state_t  cmd_state;
    logic                  act_done;
    logic                  rd_done;
    logic                  wr_done;
    logic                  pre_done;
    logic                  ref_done;
    logic                  rf_req;

    timing_regs i_timing_regs (
        .clk      (clk),
        .nRST     (nRST),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg)
    );

    timing_control i_timing_control (
        .clk       (clk),
        .nRST      (nRST),
        .cfg       (cfg),
        .cmd_state (cmd_state),
        .act_done  (act_done),
        .rd_done   (rd_done),
        .wr_done   (wr_done),
        .pre_done  (pre_done),
        .ref_done  (ref_done),
        .rf_req    (rf_req),
        .wdata_en  (wdata_en)
    );

    command_fsm i_command_fsm (
        .clk         (clk),
        .nRST        (nRST),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .act_done    (act_done),
        .rd_done     (rd_done),
        .wr_done     (wr_done),
        .pre_done    (pre_done),
        .ref_done    (ref_done),
        .rf_req      (rf_req),
        .cmd_state   (cmd_state),
        .cmd         (cmd),
        .rd_complete (rd_complete)
    );

endmodule

// ==== test/tb_dram_ctrl.sv ====
`include "dram_defs.svh"

module tb_dram_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    // rough length of each test in cycles, doubled for the timeout
    localparam int RUN_CYCLES     = 16 + 40 + 60 + 30 + 90 + 300 + 240;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    logic clk = 1'b0;
    logic nRST;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [2:0] wb_adr;
    logic [15:0] wb_dat_w, wb_dat_r;
    logic req_valid, req_ready, rd_complete, wdata_en;
    dram_pkg::mem_req_t req;
    dram_pkg::dram_cmd_t cmd;

    // expected timing register contents
    dram_pkg::cnt_t trcd_v = `DRAM_RST_TRCD;
    dram_pkg::cnt_t trp_v = `DRAM_RST_TRP;
    dram_pkg::cnt_t trfc_v = `DRAM_RST_TRFC;
    dram_pkg::cnt_t trl_v = `DRAM_RST_TRL;
    dram_pkg::cnt_t twl_v = `DRAM_RST_TWL;
    dram_pkg::ref_t trefi_v = `DRAM_RST_TREFI;

    // command log filled by the monitor
    dram_pkg::dram_cmd_t cmd_log[$];
    int cmd_cyc[$];
    int acc_cyc[$];
    int wen_cnt = 0, wen_first = 0, rdc_cnt = 0, rdc_cyc = 0;
    int cyc_cnt = 0, err_cnt = 0, fail_cnt = 0;
    logic [31:0] lfsr = 32'hea836cfe;

    dram_ctrl_top i_dut (
        .clk(clk), .nRST(nRST),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .cmd(cmd), .rd_complete(rd_complete), .wdata_en(wdata_en)
    );

    always #4 clk = ~clk;

    // cycle count doubles as the run limit
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (nRST) begin
            if (cmd.code != dram_pkg::NOP) begin
                cmd_log.push_back(cmd);
                cmd_cyc.push_back(cyc_cnt);
            end
            if (req_valid && req_ready) begin
                acc_cyc.push_back(cyc_cnt);
            end
            if (wdata_en) begin
                if (wen_cnt == 0) begin
                    wen_first = cyc_cnt;
                end
                wen_cnt++;
            end
            if (rd_complete) begin
                rdc_cnt++;
                rdc_cyc = cyc_cnt;
            end
        end
    end

    task automatic report_error(input string msg);
        err_cnt++;
        $display("[ERROR] %0t ns %s", $time, msg);
    endtask

    task automatic check_cnt(input string what, input dram_pkg::cnt_t got,
                             input dram_pkg::cnt_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_ref(input string what, input dram_pkg::ref_t got,
                             input dram_pkg::ref_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_ref_range(input string what, input dram_pkg::ref_t got,
                                   input dram_pkg::ref_t lo, input dram_pkg::ref_t hi);
        if (got < lo || got > hi) begin
            report_error($sformatf("%s: got %0d, expected %0d..%0d", what, got, lo, hi));
        end
    endtask

    task automatic check_cmd(input string what, input dram_pkg::dram_cmd_e got,
                             input dram_pkg::dram_cmd_e exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_addr(input string what, input dram_pkg::dram_cmd_t got,
                              input dram_pkg::mem_req_t exp);
        if ({got.bank, got.row, got.col} !== {exp.bank, exp.row, exp.col}) begin
            report_error($sformatf("%s: got %h/%h/%h, expected %h/%h/%h", what,
                         got.bank, got.row, got.col, exp.bank, exp.row, exp.col));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    // galois lfsr, one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_req(input logic wr, input dram_pkg::bank_t bank,
                            output dram_pkg::mem_req_t r);
        logic [31:0] bits;
        r.write = wr;
        r.bank = bank;
        take_bits(`DRAM_ROW_W, bits);
        r.row = dram_pkg::row_t'(bits);
        take_bits(`DRAM_COL_W, bits);
        r.col = dram_pkg::col_t'(bits);
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [15:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [15:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // bits above the field must read as zero
    task automatic read_cnt_reg(input string what, input logic [2:0] adr,
                                input dram_pkg::cnt_t exp);
        logic [15:0] d;
        wb_read(adr, d);
        check_cnt(what, dram_pkg::cnt_t'(d), exp);
        check_ref({what, " upper bits"}, dram_pkg::ref_t'(d >> `DRAM_CNT_W), '0);
    endtask

    task automatic read_ref_reg(input string what, input logic [2:0] adr,
                                input dram_pkg::ref_t exp);
        logic [15:0] d;
        wb_read(adr, d);
        check_ref(what, dram_pkg::ref_t'(d), exp);
        check_ref({what, " upper bits"}, dram_pkg::ref_t'(d >> `DRAM_REF_W), '0);
    endtask

    // valid stays high, the next call's first edge is the transfer
    task automatic send_req(input dram_pkg::mem_req_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req <= r;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
    endtask

    task automatic release_req();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic clear_log();
        @(posedge clk);
        cmd_log.delete();
        cmd_cyc.delete();
        acc_cyc.delete();
        wen_cnt = 0;
        rdc_cnt = 0;
    endtask

    function automatic int find_code(input dram_pkg::dram_cmd_e code);
        find_code = -1;
        for (int i = cmd_log.size() - 1; i >= 0; i--) begin
            if (cmd_log[i].code == code) begin
                find_code = i;
            end
        end
    endfunction

    function automatic dram_pkg::ref_t cmd_gap(input int i);
        return dram_pkg::ref_t'(cmd_cyc[i] - cmd_cyc[i - 1]);
    endfunction

    // ACT, RD or WR, PRE starting at log index b
    task automatic check_triple(input int b, input dram_pkg::mem_req_t r);
        dram_pkg::dram_cmd_e mid;
        dram_pkg::cnt_t lat;
        mid = r.write ? dram_pkg::WR : dram_pkg::RD;
        lat = r.write ? twl_v : trl_v;
        check_cmd("first command", cmd_log[b].code, dram_pkg::ACT);
        check_cmd("second command", cmd_log[b + 1].code, mid);
        check_cmd("third command", cmd_log[b + 2].code, dram_pkg::PRE);
        for (int i = 0; i < 3; i++) begin
            check_addr("command address", cmd_log[b + i], r);
        end
        check_ref("ACT to column command", cmd_gap(b + 1), dram_pkg::ref_t'(trcd_v));
        check_ref("column command to PRE", cmd_gap(b + 2),
                  dram_pkg::ref_t'(lat + `DRAM_TBURST));
    endtask

    task automatic run_access(input dram_pkg::mem_req_t r);
        clear_log();
        send_req(r);
        release_req();
        while (cmd_log.size() < 3) @(negedge clk);
        check_triple(0, r);
        check_ref("accept to ACT", dram_pkg::ref_t'(cmd_cyc[0] - acc_cyc[0]), 1);
        if (r.write) begin
            check_ref("wdata_en cycles", dram_pkg::ref_t'(wen_cnt), `DRAM_TBURST);
            check_ref("WR to wdata_en", dram_pkg::ref_t'(wen_first - cmd_cyc[1]), twl_v);
        end else begin
            check_ref("rd_complete pulses", dram_pkg::ref_t'(rdc_cnt), 1);
            check_ref("rd_complete to PRE", dram_pkg::ref_t'(cmd_cyc[2] - rdc_cyc), 1);
        end
    endtask

    task automatic check_after_reset();
        @(negedge clk);
        check_cmd("cmd after reset", cmd.code, dram_pkg::NOP);
        check_bit("req_ready first cycle", req_ready, 1'b0);
        check_bit("wb_ack after reset", wb_ack, 1'b0);
        check_bit("wdata_en after reset", wdata_en, 1'b0);
        check_bit("rd_complete after reset", rd_complete, 1'b0);
        @(negedge clk);
        check_bit("req_ready second cycle", req_ready, 1'b1);
    endtask

    task automatic test_regs();
        read_cnt_reg("tRCD reset", `DRAM_ADR_TRCD, `DRAM_RST_TRCD);
        read_cnt_reg("tRP reset", `DRAM_ADR_TRP, `DRAM_RST_TRP);
        read_cnt_reg("tRFC reset", `DRAM_ADR_TRFC, `DRAM_RST_TRFC);
        read_cnt_reg("tRL reset", `DRAM_ADR_TRL, `DRAM_RST_TRL);
        read_cnt_reg("tWL reset", `DRAM_ADR_TWL, `DRAM_RST_TWL);
        read_ref_reg("tREFI reset", `DRAM_ADR_TREFI, `DRAM_RST_TREFI);
        // 16'hffc7 keeps its low six bits
        trcd_v = 7;
        wb_write(`DRAM_ADR_TRCD, 16'hffc7);
        read_cnt_reg("tRCD truncated", `DRAM_ADR_TRCD, trcd_v);
        // low twelve bits of 16'hf5dc are 1500
        trefi_v = 1500;
        wb_write(`DRAM_ADR_TREFI, 16'hf5dc);
        read_ref_reg("tREFI truncated", `DRAM_ADR_TREFI, trefi_v);
        wb_write(3'd6, 16'h1234);
        read_ref_reg("unmapped 6", 3'd6, '0);
        read_ref_reg("unmapped 7", 3'd7, '0);
    endtask

    task automatic test_reads();
        dram_pkg::mem_req_t r;
        rand_req(1'b0, 2'd1, r);
        run_access(r);
        // longer activate and read latency
        trcd_v = 9;
        trl_v = 11;
        wb_write(`DRAM_ADR_TRCD, 16'(trcd_v));
        wb_write(`DRAM_ADR_TRL, 16'(trl_v));
        rand_req(1'b0, 2'd2, r);
        run_access(r);
    endtask

    task automatic test_backpressure();
        dram_pkg::mem_req_t r[3];
        for (int i = 0; i < 3; i++) begin
            rand_req(i == 1, dram_pkg::bank_t'(i + 1), r[i]);
        end
        clear_log();
        for (int i = 0; i < 3; i++) begin
            send_req(r[i]);
        end
        release_req();
        while (cmd_log.size() < 9) @(negedge clk);
        check_ref("accepted requests", dram_pkg::ref_t'(acc_cyc.size()), 3);
        for (int i = 0; i < 3; i++) begin
            check_triple(3 * i, r[i]);
        end
        for (int i = 1; i < 3; i++) begin
            check_ref_range("PRE to next ACT", cmd_gap(3 * i), trp_v + 1, '1);
        end
    endtask

    task automatic test_refresh();
        dram_pkg::mem_req_t r;
        int ia;
        // count is far past the new limit, refresh due at once
        clear_log();
        trefi_v = 60;
        wb_write(`DRAM_ADR_TREFI, 16'(trefi_v));
        rand_req(1'b0, 2'd3, r);
        send_req(r);
        release_req();
        while (find_code(dram_pkg::PRE) < 0) @(negedge clk);
        ia = find_code(dram_pkg::ACT);
        if (ia < 1) begin
            fail_cnt++;
            $display("request was not held back behind the due refresh");
        end else begin
            for (int i = 0; i < ia; i++) begin
                check_cmd("before ACT", cmd_log[i].code, dram_pkg::REF);
            end
            check_ref_range("REF to ACT", cmd_gap(ia), trfc_v + 1, '1);
            check_triple(ia, r);
        end
        // idle, refreshes come one limit apart
        clear_log();
        while (cmd_log.size() < 3) @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            check_cmd("idle refresh", cmd_log[i].code, dram_pkg::REF);
        end
        for (int i = 1; i < 3; i++) begin
            check_ref_range("REF to REF", cmd_gap(i), trfc_v + 1, trefi_v + 2);
        end
    endtask

    task automatic test_debt();
        dram_pkg::mem_req_t r;
        int ov;
        int late;
        // long write keeps the bank busy past the refresh limit
        twl_v = 50;
        wb_write(`DRAM_ADR_TWL, 16'(twl_v));
        clear_log();
        while (cmd_log.size() < 1) @(negedge clk);
        rand_req(1'b1, 2'd2, r);
        send_req(r);
        release_req();
        while (cmd_log.size() < 6) @(negedge clk);
        check_cmd("anchor refresh", cmd_log[0].code, dram_pkg::REF);
        check_triple(1, r);
        check_cmd("delayed refresh", cmd_log[4].code, dram_pkg::REF);
        check_cmd("next refresh", cmd_log[5].code, dram_pkg::REF);
        check_ref("wdata_en cycles", dram_pkg::ref_t'(wen_cnt), `DRAM_TBURST);
        check_ref("WR to wdata_en", dram_pkg::ref_t'(wen_first - cmd_cyc[2]), twl_v);
        // refresh count at the delayed REF, beyond tREFI
        ov = cmd_cyc[4] - cmd_cyc[0] - 1 - trefi_v;
        if (ov <= 0) begin
            fail_cnt++;
            $display("the long write did not delay the refresh");
        end else begin
            late = (trefi_v - ov > trfc_v) ? trefi_v - ov : trfc_v;
            check_ref_range("REF after debt", cmd_gap(5), trfc_v + 1,
                            dram_pkg::ref_t'(late + 2));
        end
    endtask

    initial begin
        nRST = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        req_valid = 1'b0;
        req = '0;
        repeat (16) @(posedge clk);
        nRST <= 1'b1;
        check_after_reset();
        test_regs();
        test_reads();
        begin : write_case
            dram_pkg::mem_req_t r;
            rand_req(1'b1, 2'd0, r);
            run_access(r);
        end
        test_backpressure();
        test_refresh();
        test_debt();
        $display("summary: %0d mismatches, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/dram_pkg.sv
logic/flex_counter.sv
logic/timing_regs.sv
logic/timing_control.sv
logic/command_fsm.sv
logic/dram_ctrl_top.sv
test/tb_dram_ctrl.sv

// ==== Bender.yml ====
package:
  name: dram_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/dram_pkg.sv
      - logic/flex_counter.sv
      - logic/timing_regs.sv
      - logic/timing_control.sv
      - logic/command_fsm.sv
      - logic/dram_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_dram_ctrl.sv
